/* Makefile */
# Verilator build and run for the riscv_small testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_riscv_small
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_TEXT := Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/riscv_small_checker.sv */
//####################
// riscv_small port checker
// memory handshake assertions, bound to the core
//####################
`timescale 1ns/100ps
`default_nettype none

module riscv_small_checker import rv_isa_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  inst_rd_en,
    input logic  inst_ready,
    input word_t inst_addr,
    input logic  data_rd_en,
    input logic  data_wr_en,
    input logic  data_ready,
    input word_t data_addr,
    input word_t data_wr
);

    // one data access at a time
    a_one_enable: assert property (@(posedge clk) disable iff (!rst_n)
        !(data_rd_en && data_wr_en))
        else $error("both data enables high");

    a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        data_rd_en && !data_ready |=> data_rd_en && $stable(data_addr))
        else $error("data read dropped before ready");

    a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        data_wr_en && !data_ready |=> data_wr_en && $stable(data_addr) && $stable(data_wr))
        else $error("data write changed before ready");

    a_inst_hold: assert property (@(posedge clk) disable iff (!rst_n)
        inst_rd_en && !inst_ready |=> inst_rd_en && $stable(inst_addr))
        else $error("fetch address changed before ready");

    // async reset clears every request
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !data_rd_en && !data_wr_en && !inst_rd_en)
        else $error("enable high in reset");

    a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        inst_addr[1:0] == 2'b00)
        else $error("fetch address not word aligned");

endmodule : riscv_small_checker

bind riscv_small riscv_small_checker chk0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_rd_en (inst_rd_en),
    .inst_ready (inst_ready),
    .inst_addr  (inst_addr),
    .data_rd_en (data_rd_en),
    .data_wr_en (data_wr_en),
    .data_ready (data_ready),
    .data_addr  (data_addr),
    .data_wr    (data_wr)
);

`default_nettype wire

/* bench/tb_riscv_small.sv */
//####################
// riscv_small testbench
// rom and ram models, isa reference model, store compare
//####################
`timescale 1ns/100ps
`default_nettype none

module tb_riscv_small import rv_isa_pkg::*; ;

    localparam int SEED = 42512;

    logic  clk;
    logic  rst_n;
    logic  inst_ready;
    inst_t inst_data;
    word_t inst_addr;
    logic  inst_rd_en;
    logic  data_ready;
    word_t data_rd;
    logic  data_rd_en;
    logic  data_wr_en;
    word_t data_wr;
    word_t data_addr;

    inst_t prog [$];        // straight-line program
    inst_t rom [64];
    word_t ram [64];
    word_t exp_addr [$];    // expected stores, in order
    word_t exp_data [$];
    int    store_idx;
    int    cycles;
    int    cycle_limit;
    logic  random_ready;
    string test_name;

    riscv_small #(.RESET_PC('0)) dut0 (
        .clk(clk), .rst_n(rst_n),
        .inst_ready(inst_ready), .inst_data(inst_data),
        .inst_addr(inst_addr), .inst_rd_en(inst_rd_en),
        .data_ready(data_ready), .data_rd(data_rd),
        .data_rd_en(data_rd_en), .data_wr_en(data_wr_en),
        .data_wr(data_wr), .data_addr(data_addr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    // instruction encoders
    function automatic inst_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input funct3_t f3,
                                     input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic inst_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                     input funct3_t f3, input reg_addr_t rd,
                                     input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic inst_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic inst_t u_type(input logic [19:0] imm, input reg_addr_t rd);
        return {imm, rd, 7'b0110111};
    endfunction

    // preset contents depend on every address bit
    function automatic word_t ram_fill(input int i);
        return {i[7:0] ^ 8'hc3, ~i[7:0], i[7:0], 8'h5a};
    endfunction

    function automatic inst_t rom_word(input word_t addr);
        if (addr[31:8] != '0)
            return NOP_INST;   // past the rom
        return rom[addr[7:2]];
    endfunction

    // one rv32i alu op, alt is the funct7 bit 30
    function automatic word_t alu_ref(input funct3_t f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // isa level run of prog, fills the expected store list
    function automatic void rv_model();
        word_t     x [32];
        word_t     m [64];
        inst_t     w;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        funct3_t   f3;
        word_t     imm_i;
        word_t     imm_s;
        word_t     addr;
        word_t     res;
        logic      wr;
        for (int i = 0; i < 32; i++)
            x[i] = '0;
        for (int i = 0; i < 64; i++)
            m[i] = ram_fill(i);
        exp_addr.delete();
        exp_data.delete();
        for (int k = 0; k < prog.size(); k++) begin
            w     = prog[k];
            rd    = w[11:7];
            rs1   = w[19:15];
            rs2   = w[24:20];
            f3    = w[14:12];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
            wr    = 1'b1;
            res   = '0;
            case (w[6:0])
                7'b0110011: res = alu_ref(f3, w[30], x[rs1], x[rs2]);
                7'b0010011: res = alu_ref(f3, w[30] && f3 == 3'd5, x[rs1], imm_i);
                7'b0110111: res = {w[31:12], 12'b0};
                7'b0000011: begin
                    addr = x[rs1] + imm_i;
                    res  = m[addr[7:2]];
                end
                7'b0100011: begin
                    wr   = 1'b0;
                    addr = x[rs1] + imm_s;
                    exp_addr.push_back(addr);
                    exp_data.push_back(x[rs2]);
                    m[addr[7:2]] = x[rs2];
                end
                default: wr = 1'b0;
            endcase
            if (wr && rd != '0)
                x[rd] = res;   // x0 stays zero
        end
    endfunction

    task automatic build_program();
        prog.push_back(i_type(12'd128, 5'd0, 3'd0, 5'd20, 7'b0010011));   // base
        prog.push_back(i_type(12'd100, 5'd0, 3'd0, 5'd1, 7'b0010011));
        prog.push_back(i_type(-12'sd7, 5'd0, 3'd0, 5'd2, 7'b0010011));
        prog.push_back(s_type(12'd0, 5'd2, 5'd20));                   // store of fresh x2
        prog.push_back(u_type(20'h12345, 5'd3));
        prog.push_back(s_type(12'd4, 5'd3, 5'd20));
        prog.push_back(i_type(12'd5, 5'd2, 3'd2, 5'd4, 7'b0010011));      // slti
        prog.push_back(i_type(12'd5, 5'd2, 3'd3, 5'd5, 7'b0010011));      // sltiu
        prog.push_back(i_type(12'h0f0, 5'd1, 3'd4, 5'd6, 7'b0010011));
        prog.push_back(i_type(12'h678, 5'd3, 3'd6, 5'd7, 7'b0010011));
        prog.push_back(i_type(12'h03c, 5'd2, 3'd7, 5'd8, 7'b0010011));
        prog.push_back(i_type(12'd3, 5'd1, 3'd1, 5'd9, 7'b0010011));      // slli
        prog.push_back(i_type(12'd4, 5'd2, 3'd5, 5'd10, 7'b0010011));     // srli
        prog.push_back(i_type(12'h402, 5'd2, 3'd5, 5'd11, 7'b0010011));   // srai
        for (int r = 4; r <= 11; r++)
            prog.push_back(s_type(12'(4 * r), 5'(r), 5'd20));
        // dependent register-register chain
        prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd12));
        prog.push_back(r_type(7'h20, 5'd1, 5'd12, 3'd0, 5'd13));          // sub from ma
        prog.push_back(r_type(7'h00, 5'd13, 5'd1, 3'd1, 5'd14));
        prog.push_back(r_type(7'h00, 5'd14, 5'd12, 3'd4, 5'd15));
        prog.push_back(r_type(7'h00, 5'd12, 5'd13, 3'd2, 5'd16));
        prog.push_back(r_type(7'h00, 5'd12, 5'd13, 3'd3, 5'd17));
        prog.push_back(r_type(7'h00, 5'd16, 5'd13, 3'd5, 5'd18));
        prog.push_back(r_type(7'h20, 5'd16, 5'd13, 3'd5, 5'd19));
        prog.push_back(r_type(7'h00, 5'd19, 5'd18, 3'd6, 5'd21));
        prog.push_back(r_type(7'h00, 5'd15, 5'd21, 3'd7, 5'd22));
        for (int r = 12; r <= 19; r++)
            prog.push_back(s_type(12'(4 * r - 8), 5'(r), 5'd20));
        prog.push_back(s_type(12'd72, 5'd21, 5'd20));
        prog.push_back(s_type(12'd76, 5'd22, 5'd20));
        // load-use pairs
        prog.push_back(i_type(12'd8, 5'd0, 3'd2, 5'd23, 7'b0000011));
        prog.push_back(r_type(7'h00, 5'd1, 5'd23, 3'd0, 5'd24));
        prog.push_back(s_type(12'd80, 5'd24, 5'd20));
        prog.push_back(i_type(12'd0, 5'd20, 3'd2, 5'd25, 7'b0000011));
        prog.push_back(r_type(7'h20, 5'd25, 5'd1, 3'd0, 5'd26));
        prog.push_back(s_type(12'd84, 5'd26, 5'd20));
        prog.push_back(i_type(12'd55, 5'd0, 3'd0, 5'd0, 7'b0010011));     // write to x0
        prog.push_back(s_type(12'd88, 5'd0, 5'd20));
        prog.push_back(i_type(12'd4, 5'd20, 3'd2, 5'd27, 7'b0000011));
        prog.push_back(s_type(12'd92, 5'd27, 5'd20));                     // load into store data
        for (int i = 0; i < 64; i++)
            rom[i] = (i < prog.size()) ? prog[i] : NOP_INST;
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_addr(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            fail_run($sformatf("CHECK FAILED %s store address: expected %h, actual %h",
                               name, exp, act));
    endtask

    task automatic check_data(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            fail_run($sformatf("CHECK FAILED %s store data: expected %h, actual %h",
                               name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
            fail_run($sformatf("CHECK FAILED %s store count: expected %0d, actual %0d",
                               name, exp, act));
    endtask

    // memory models, driven on the falling edge
    always @(negedge clk) begin
        if (random_ready) begin
            inst_ready = ($urandom % 100) >= 30;   // low about 30 percent
            data_ready = ($urandom % 100) >= 30;
        end else begin
            inst_ready = 1'b1;
            data_ready = 1'b1;
        end
        inst_data = inst_rd_en ? rom_word(inst_addr) : NOP_INST;
        data_rd   = data_rd_en ? ram[data_addr[7:2]] : '0;   // only a requested read
    end

    // store compare, a store ends with enable and ready high
    always @(posedge clk) begin
        if (rst_n && data_wr_en && data_ready) begin
            if (store_idx < exp_addr.size()) begin
                check_addr(test_name, exp_addr[store_idx], data_addr);
                check_data(test_name, exp_data[store_idx], data_wr);
                ram[data_addr[7:2]] = data_wr;
            end
            store_idx++;   // extra stores land in the count
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit)
            fail_run($sformatf("timeout: no finish after %0d cycles", cycles));
    end

    task automatic run_program(input logic rand_ready, input string name);
        @(negedge clk);
        rst_n        = 1'b0;
        random_ready = rand_ready;
        test_name    = name;
        store_idx    = 0;
        for (int i = 0; i < 64; i++)
            ram[i] = ram_fill(i);
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        while (store_idx < exp_addr.size())
            @(posedge clk);
        repeat (40) @(posedge clk);   // drain, catch extra stores
        check_count(name, exp_addr.size(), store_idx);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n        = 1'b0;
        inst_ready   = 1'b0;
        inst_data    = NOP_INST;
        data_ready   = 1'b0;
        data_rd      = '0;
        random_ready = 1'b0;
        store_idx    = 0;
        cycles       = 0;
        build_program();
        cycle_limit  = 2 * (40 * prog.size() + 100);   // two runs plus margin
        rv_model();
        run_program(1'b0, "ready always high");
        run_program(1'b1, "random ready");
        $display("Everything OK");
        $finish;
    end

endmodule : tb_riscv_small

`default_nettype wire

/* filelist.f */
rtl/rv_isa_pkg.sv
rtl/rv_pipe_pkg.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_mem_access.sv
rtl/rv_hazard.sv
rtl/riscv_small.sv
bench/riscv_small_checker.sv
bench/tb_riscv_small.sv

/* rtl/riscv_small.sv */
//####################
// riscv_small core
// five-stage rv32i pipeline with hazard unit
//####################
`timescale 1ns/100ps
`default_nettype none

module riscv_small import rv_isa_pkg::*, rv_pipe_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  inst_ready,   // instruction word valid
    input  inst_t inst_data,
    output word_t inst_addr,
    output logic  inst_rd_en,
    input  logic  data_ready,   // completes the pending data access
    input  word_t data_rd,
    output logic  data_rd_en,
    output logic  data_wr_en,
    output word_t data_wr,
    output word_t data_addr
);

    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_ma_t   ex_ma;
    wb_t      wb;
    logic     stall_all;
    logic     hold_front;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    rv_fetch #(.RESET_PC(RESET_PC)) u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall_all  (stall_all),
        .hold_front (hold_front),
        .inst_ready (inst_ready),
        .inst_data  (inst_data),
        .inst_addr  (inst_addr),
        .inst_rd_en (inst_rd_en),
        .if_id      (if_id)
    );

    rv_decode u_decode (
        .clk(clk), .rst_n(rst_n), .stall_all(stall_all), .hold_front(hold_front),
        .if_id(if_id), .wb(wb), .id_ex(id_ex)
    );

    rv_execute u_execute (
        .clk(clk), .rst_n(rst_n), .stall_all(stall_all), .id_ex(id_ex),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .ex_ma(ex_ma), .wb(wb)
    );

    rv_mem_access u_mem_access (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall_all  (stall_all),
        .ex_ma      (ex_ma),
        .data_rd    (data_rd),
        .data_addr  (data_addr),
        .data_wr    (data_wr),
        .data_rd_en (data_rd_en),
        .data_wr_en (data_wr_en),
        .wb         (wb)          // back to regfile and forwarding
    );

    rv_hazard u_hazard (
        .if_id(if_id), .id_ex(id_ex), .ex_ma(ex_ma), .wb(wb),
        .inst_ready(inst_ready), .data_ready(data_ready),
        .stall_all(stall_all), .hold_front(hold_front), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

endmodule : riscv_small

`default_nettype wire

/* rtl/rv_decode.sv */
//####################
// instruction decode
// register file, decoder, immediates and ID/EX register
//####################
`timescale 1ns/100ps
`default_nettype none

module rv_decode import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   stall_all,
    input  logic   hold_front,   // load-use bubble into ID/EX
    input  if_id_t if_id,
    input  wb_t    wb,           // register write port
    output id_ex_t id_ex
);

    word_t     regs [NUM_REGS];   // x0 never written
    inst_t     inst;
    reg_addr_t rs1;
    reg_addr_t rs2;
    funct3_t   f3;
    id_ex_t    dec;

    assign inst = if_id.inst;
    assign rs1  = inst[19:15];
    assign rs2  = inst[24:20];
    assign f3   = inst[14:12];

    // write on the edge, x0 stays zero
    always_ff @(posedge clk) begin
        if (wb.we && wb.rd != '0)
            regs[wb.rd] <= wb.data;
    end

    // read with write-through from wb
    function automatic word_t rf_read(input reg_addr_t idx);
        if (idx == '0)
            return '0;
        if (wb.we && wb.rd == idx)
            return wb.data;                        // same-cycle write wins
        return regs[idx];
    endfunction

    always_comb begin
        dec          = '0;
        dec.valid    = if_id.valid;
        dec.rd       = inst[11:7];
        dec.rs1      = rs1;
        dec.rs2      = rs2;
        dec.rs1_data = rf_read(rs1);
        dec.rs2_data = rf_read(rs2);
        case (opcode_e'(inst[6:0]))
            OP: begin
                dec.we     = 1'b1;
                dec.alu_op = alu_op_e'({inst[30] && (f3 == F3_ADD_SUB || f3 == F3_SR), f3});
            end
            OP_IMM: begin
                dec.we      = 1'b1;
                dec.use_imm = 1'b1;
                dec.rs2     = '0;                  // field is immediate bits
                dec.imm     = {{20{inst[31]}}, inst[31:20]};
                dec.alu_op  = alu_op_e'({inst[30] && f3 == F3_SR, f3});   // no subi
            end
            LUI: begin
                dec.we      = 1'b1;
                dec.use_imm = 1'b1;
                dec.rs1     = '0;
                dec.rs2     = '0;
                dec.imm     = {inst[31:12], 12'b0};
                dec.alu_op  = ALU_PASS_B;
            end
            LOAD: begin
                dec.valid   = if_id.valid && f3 == F3_LW_SW;
                dec.we      = 1'b1;
                dec.is_load = 1'b1;
                dec.use_imm = 1'b1;
                dec.rs2     = '0;
                dec.imm     = {{20{inst[31]}}, inst[31:20]};
                dec.alu_op  = ALU_ADD;             // address = rs1 + imm
            end
            STORE: begin
                dec.valid    = if_id.valid && f3 == F3_LW_SW;
                dec.is_store = 1'b1;
                dec.use_imm  = 1'b1;
                dec.rd       = '0;
                dec.imm      = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                dec.alu_op   = ALU_ADD;
            end
            default: dec.valid = 1'b0;             // unknown opcode is a bubble
        endcase
        if (!dec.valid) begin
            dec.we       = 1'b0;
            dec.is_load  = 1'b0;
            dec.is_store = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            id_ex <= '0;
        else if (!stall_all)
            id_ex <= hold_front ? '0 : dec;        // zero struct is a bubble
    end

endmodule : rv_decode

`default_nettype wire

/* rtl/rv_execute.sv */
//####################
// execute stage
// operand forwarding, alu and EX/MA register
//####################
`timescale 1ns/100ps
`default_nettype none

module rv_execute import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall_all,
    input  id_ex_t   id_ex,
    input  fwd_sel_e fwd_a,
    input  fwd_sel_e fwd_b,
    output ex_ma_t   ex_ma,      // read back as the MA forward source
    input  wb_t      wb
);

    word_t op_a;
    word_t rs2_val;   // forwarded rs2, also store data
    word_t op_b;
    word_t alu_res;

    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val);
        case (sel)
            FWD_MA:  return ex_ma.result;          // never a load, hazard unit stalls those
            FWD_WB:  return wb.data;
            default: return reg_val;
        endcase
    endfunction

    assign op_a    = fwd_mux(fwd_a, id_ex.rs1_data);
    assign rs2_val = fwd_mux(fwd_b, id_ex.rs2_data);
    assign op_b    = id_ex.use_imm ? id_ex.imm : rs2_val;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << op_b[4:0];
            ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> op_b[4:0];
            ALU_SRA:    alu_res = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;            // lui
            default:    alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_ma <= '0;
        end else if (!stall_all) begin
            ex_ma <= '{
                valid:      id_ex.valid,
                rd:         id_ex.rd,
                we:         id_ex.we,
                is_load:    id_ex.is_load,
                is_store:   id_ex.is_store,
                result:     alu_res,
                store_data: rs2_val
            };
        end
    end

endmodule : rv_execute

`default_nettype wire

/* rtl/rv_fetch.sv */
//####################
// instruction fetch
// pc, instruction port request and IF/ID register
//####################
`timescale 1ns/100ps
`default_nettype none

module rv_fetch import rv_isa_pkg::*, rv_pipe_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   stall_all,    // memory wait, freeze all
    input  logic   hold_front,   // load-use, freeze pc and IF/ID
    input  logic   inst_ready,
    input  inst_t  inst_data,
    output word_t  inst_addr,
    output logic   inst_rd_en,
    output if_id_t if_id
);

    word_t pc;
    logic  rd_en_q;    // low only during reset
    logic  accept;     // word taken this cycle

    assign inst_addr  = pc;
    assign inst_rd_en = rd_en_q;
    assign accept     = rd_en_q && inst_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= RESET_PC;
            rd_en_q <= 1'b0;
            if_id   <= '{valid: 1'b0, inst: NOP_INST, pc: RESET_PC};
        end else begin
            rd_en_q <= 1'b1;                       // request from first cycle on
            if (!stall_all && !hold_front) begin
                if (accept) begin
                    if_id <= '{valid: 1'b1, inst: inst_data, pc: pc};
                    pc    <= pc + word_t'(4);      // next sequential word
                end else begin
                    if_id.valid <= 1'b0;           // bubble while memory is slow
                    if_id.inst  <= NOP_INST;
                end
            end
            // a word served during a stall is dropped, same address asked again
        end
    end

endmodule : rv_fetch

`default_nettype wire

/* rtl/rv_hazard.sv */
//####################
// hazard unit
// load-use and memory-wait stalls, forwarding selects
//####################
`timescale 1ns/100ps
`default_nettype none

module rv_hazard import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  if_id_t   if_id,
    input  id_ex_t   id_ex,
    input  ex_ma_t   ex_ma,
    input  wb_t      wb,
    input  logic     inst_ready,
    input  logic     data_ready,
    output logic     stall_all,
    output logic     hold_front,
    output fwd_sel_e fwd_a,
    output fwd_sel_e fwd_b
);

    reg_addr_t id_rs1;
    reg_addr_t id_rs2;
    logic      data_wait;

    assign id_rs1 = if_id.inst[19:15];
    assign id_rs2 = if_id.inst[24:20];

    assign data_wait = (ex_ma.valid && (ex_ma.is_load || ex_ma.is_store)) && !data_ready;
    assign stall_all = data_wait;

    // load result not ready before wb, one bubble needed
    assign hold_front = id_ex.we && id_ex.is_load && id_ex.rd != '0 &&
                        (id_ex.rd == id_rs1 || id_ex.rd == id_rs2);

    // nearer stage first, x0 never forwarded
    function automatic fwd_sel_e pick(input reg_addr_t src);
        if (src == '0)
            return FWD_NONE;
        if (ex_ma.we && ex_ma.rd == src)
            return FWD_MA;
        if (wb.we && wb.rd == src)
            return FWD_WB;
        return FWD_NONE;
    endfunction

    assign fwd_a = pick(id_ex.rs1);
    assign fwd_b = pick(id_ex.rs2);

endmodule : rv_hazard

`default_nettype wire

/* rtl/rv_isa_pkg.sv */
//####################
// rv32i instruction set definitions
// encodings, field widths and alu operations
//####################
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN     = 32;   // data path width
    localparam int REG_AW   = 5;    // register index width
    localparam int NUM_REGS = 32;   // x0..x31

    typedef logic [XLEN-1:0]   word_t;      // data or address word
    typedef logic [31:0]       inst_t;      // raw instruction word
    typedef logic [REG_AW-1:0] reg_addr_t;  // register index
    typedef logic [2:0]        funct3_t;

    // major opcodes still in use
    typedef enum logic [6:0] {
        OP     = 7'b0110011,   // register-register alu
        OP_IMM = 7'b0010011,   // register-immediate alu
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_e;

    // funct3 codes for alu and memory ops
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SR      = 3'b101;   // srl or sra by funct7
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;
    localparam funct3_t F3_LW_SW   = 3'b010;   // word access only

    // low three bits follow funct3, msb is the funct7 alternate bit
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SLL    = 4'b0001,
        ALU_SLT    = 4'b0010,
        ALU_SLTU   = 4'b0011,
        ALU_XOR    = 4'b0100,
        ALU_SRL    = 4'b0101,
        ALU_OR     = 4'b0110,
        ALU_AND    = 4'b0111,
        ALU_SUB    = 4'b1000,
        ALU_SRA    = 4'b1101,
        ALU_PASS_B = 4'b1111    // lui, immediate straight through
    } alu_op_e;

    localparam inst_t NOP_INST = 32'h0000_0013;   // addi x0,x0,0

endpackage : rv_isa_pkg

`default_nettype wire

/* rtl/rv_mem_access.sv */
//####################
// memory access stage
// data port drive, MA/WB register, writeback select
//####################
`timescale 1ns/100ps
`default_nettype none

module rv_mem_access import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   stall_all,    // held while the data port waits
    input  ex_ma_t ex_ma,
    input  word_t  data_rd,
    output word_t  data_addr,
    output word_t  data_wr,
    output logic   data_rd_en,
    output logic   data_wr_en,
    output wb_t    wb
);

    logic      wb_we;
    reg_addr_t wb_rd;
    logic      wb_load;     // picks load data over alu result
    word_t     wb_alu;
    word_t     wb_ld_data;

    // port signals come straight from EX/MA, stable while frozen
    assign data_addr  = ex_ma.result;
    assign data_wr    = ex_ma.store_data;
    assign data_rd_en = ex_ma.valid && ex_ma.is_load;
    assign data_wr_en = ex_ma.valid && ex_ma.is_store;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we   <= 1'b0;
            wb_rd   <= '0;
            wb_load <= 1'b0;
        end else if (!stall_all) begin
            wb_we   <= ex_ma.we;
            wb_rd   <= ex_ma.rd;
            wb_load <= ex_ma.is_load;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_all) begin
            wb_alu     <= ex_ma.result;
            wb_ld_data <= data_rd;                 // valid in the ready cycle
        end
    end

    assign wb = '{we: wb_we, rd: wb_rd, data: wb_load ? wb_ld_data : wb_alu};

endmodule : rv_mem_access

`default_nettype wire

/* rtl/rv_pipe_pkg.sv */
//####################
// pipeline register types
// structs carried between the five stages
//####################
`default_nettype none

package rv_pipe_pkg;

    import rv_isa_pkg::*;

    // fetch to decode
    typedef struct packed {
        logic  valid;
        inst_t inst;
        word_t pc;
    } if_id_t;

    // decode to execute
    typedef struct packed {
        logic      valid;
        reg_addr_t rs1;        // source indexes kept for forwarding
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      we;         // register write enable
        logic      is_load;
        logic      is_store;
        alu_op_e   alu_op;
        logic      use_imm;    // imm replaces operand b
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
    } id_ex_t;

    // execute to memory access
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        logic      we;
        logic      is_load;
        logic      is_store;
        word_t     result;      // alu result, also the data address
        word_t     store_data;  // forwarded rs2
    } ex_ma_t;

    // writeback, also the forwarding source from wb
    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_MA   = 2'b01,
        FWD_WB   = 2'b10
    } fwd_sel_e;

endpackage : rv_pipe_pkg

`default_nettype wire
